// ==== fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    redirect_valid,
  input  mem_sys_pkg::byte_pc_t   redirect_pc,
  input  logic                    fetch_gnt,
  input  logic                    rd_valid,
  input  mem_sys_pkg::word_t      mem_rdata,
  input  logic                    fetched_ready,
  output logic                    fetch_req,
  output mem_sys_pkg::word_addr_t fetch_addr,
  output logic                    fetched_valid,
  output rv_isa_pkg::instr_t      fetched_instr,
  output mem_sys_pkg::byte_pc_t   fetched_pc
);

  // PC of the last word, the next one wraps to zero
  localparam mem_sys_pkg::byte_pc_t LAST_PC = mem_sys_pkg::byte_pc_t'((MEM_WORDS - 1) * 4);

  mem_sys_pkg::byte_pc_t pc;
  logic                  running;
  logic                  epoch;
  logic                  pend_epoch;
  mem_sys_pkg::byte_pc_t pend_pc;
  rv_isa_pkg::instr_t    q_instr [2];
  mem_sys_pkg::byte_pc_t q_pc [2];
  logic                  wr_ptr;
  logic                  rd_ptr;
  logic [1:0]            count;
  logic                  push;
  logic                  pop;

  // Queue slots in use count the read still in flight
  assign fetch_req  = running && ((count + {1'b0, rd_valid}) < 2'd2);
  assign fetch_addr = pc[mem_sys_pkg::ADDR_W+1:2];

  // Reads from before a redirect carry the old epoch
  assign push = rd_valid && (pend_epoch == epoch) && !redirect_valid;
  assign pop  = fetched_valid && fetched_ready;

  assign fetched_valid = (count != 2'd0);
  assign fetched_instr = q_instr[rd_ptr];
  assign fetched_pc    = q_pc[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc      <= '0;
      running <= 1'b0;
      epoch   <= 1'b0;
    end else if (redirect_valid) begin
      pc      <= redirect_pc;
      running <= 1'b1;
      epoch   <= ~epoch;
    end else if (fetch_gnt) begin
      pc <= (pc == LAST_PC) ? '0 : pc + 32'd4;
    end
  end

  // Tag of the read granted this cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_epoch <= 1'b0;
    end else if (fetch_gnt) begin
      pend_epoch <= epoch;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_gnt) begin
      pend_pc <= pc;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else if (redirect_valid) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_instr[wr_ptr] <= mem_rdata;
      q_pc[wr_ptr]    <= pend_pc;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) push |-> (count != 2'd2))
    else $error("fetch_unit: return queue overflow");

  // Every grant comes back next cycle into a queue that still has room
  assert property (@(posedge clk) disable iff (!rst_n)
    fetch_gnt |=> (rd_valid && (count != 2'd2)))
    else $error("fetch_unit: read granted without a free slot");

endmodule

// ==== instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
  input  logic                  fetched_valid,
  input  rv_isa_pkg::instr_t    fetched_instr,
  input  mem_sys_pkg::byte_pc_t fetched_pc,
  input  logic                  dec_ready,
  output logic                  fetched_ready,
  output logic                  dec_valid,
  output mem_sys_pkg::byte_pc_t dec_pc,
  output rv_isa_pkg::instr_op_e dec_op,
  output rv_isa_pkg::reg_idx_t  dec_rd,
  output rv_isa_pkg::reg_idx_t  dec_rs1,
  output rv_isa_pkg::reg_idx_t  dec_rs2,
  output rv_isa_pkg::imm_t      dec_imm,
  output rv_isa_pkg::funct3_t   dec_funct3
);

  rv_isa_pkg::instr_t     from;
  rv_isa_pkg::instr_fmt_e fmt;
  logic                   sign_bit;
  logic                   has_rs1;
  logic                   has_rs2;
  logic                   has_rd;

  // Pure combinational stage, handshake passes straight through
  assign from          = fetched_instr;
  assign dec_valid     = fetched_valid;
  assign fetched_ready = dec_ready;
  assign dec_pc        = fetched_pc;

  always_comb begin
    dec_op = rv_isa_pkg::INSTR_INVAL;
    fmt    = rv_isa_pkg::INSTR_FMT_NONE;
    // No compressed encodings
    if (from[1:0] == rv_isa_pkg::LEN_32) begin
      case (from[6:2])
        rv_isa_pkg::OPC_LOAD: begin
          dec_op = rv_isa_pkg::INSTR_LOAD;
          fmt    = rv_isa_pkg::INSTR_I;
        end
        // FENCE fields sit in the I immediate
        rv_isa_pkg::OPC_MISC_MEM: begin
          dec_op = rv_isa_pkg::INSTR_MISC_MEM;
          fmt    = rv_isa_pkg::INSTR_I;
        end
        rv_isa_pkg::OPC_OP_IMM: begin
          dec_op = rv_isa_pkg::INSTR_OP_IMM;
          fmt    = rv_isa_pkg::INSTR_I;
        end
        rv_isa_pkg::OPC_AUIPC: begin
          dec_op = rv_isa_pkg::INSTR_AUIPC;
          fmt    = rv_isa_pkg::INSTR_U;
        end
        rv_isa_pkg::OPC_STORE: begin
          dec_op = rv_isa_pkg::INSTR_STORE;
          fmt    = rv_isa_pkg::INSTR_S;
        end
        rv_isa_pkg::OPC_OP: begin
          dec_op = rv_isa_pkg::INSTR_OP;
          fmt    = rv_isa_pkg::INSTR_R;
        end
        rv_isa_pkg::OPC_LUI: begin
          dec_op = rv_isa_pkg::INSTR_LUI;
          fmt    = rv_isa_pkg::INSTR_U;
        end
        rv_isa_pkg::OPC_BRANCH: begin
          dec_op = rv_isa_pkg::INSTR_BRANCH;
          fmt    = rv_isa_pkg::INSTR_B;
        end
        rv_isa_pkg::OPC_JALR: begin
          dec_op = rv_isa_pkg::INSTR_JALR;
          fmt    = rv_isa_pkg::INSTR_I;
        end
        rv_isa_pkg::OPC_JAL: begin
          dec_op = rv_isa_pkg::INSTR_JAL;
          fmt    = rv_isa_pkg::INSTR_J;
        end
        // CSR number and flags come out in the immediate
        rv_isa_pkg::OPC_SYSTEM: begin
          dec_op = rv_isa_pkg::INSTR_SYSTEM;
          fmt    = rv_isa_pkg::INSTR_I;
        end
        default: begin
          dec_op = rv_isa_pkg::INSTR_INVAL;
          fmt    = rv_isa_pkg::INSTR_FMT_NONE;
        end
      endcase
    end
  end

  // Register fields present per format
  assign has_rs1 = (fmt == rv_isa_pkg::INSTR_R) || (fmt == rv_isa_pkg::INSTR_I) ||
                   (fmt == rv_isa_pkg::INSTR_S) || (fmt == rv_isa_pkg::INSTR_B);
  assign has_rs2 = (fmt == rv_isa_pkg::INSTR_R) || (fmt == rv_isa_pkg::INSTR_S) ||
                   (fmt == rv_isa_pkg::INSTR_B);
  assign has_rd  = (fmt == rv_isa_pkg::INSTR_R) || (fmt == rv_isa_pkg::INSTR_I) ||
                   (fmt == rv_isa_pkg::INSTR_U) || (fmt == rv_isa_pkg::INSTR_J);

  assign dec_rs1 = has_rs1 ? from[19:15] : '0;
  assign dec_rs2 = has_rs2 ? from[24:20] : '0;
  assign dec_rd  = has_rd ? from[11:7] : '0;

  assign sign_bit = from[31];

  // R-type shares the I layout, so funct7 lands in imm[11:5]
  always_comb begin
    case (fmt)
      rv_isa_pkg::INSTR_R, rv_isa_pkg::INSTR_I:
        dec_imm = {{20{sign_bit}}, from[31:20]};
      rv_isa_pkg::INSTR_S:
        dec_imm = {{20{sign_bit}}, from[31:25], from[11:7]};
      rv_isa_pkg::INSTR_B:
        dec_imm = {{19{sign_bit}}, from[31], from[7], from[30:25], from[11:8], 1'b0};
      rv_isa_pkg::INSTR_U:
        dec_imm = {from[31:12], 12'b0};
      rv_isa_pkg::INSTR_J:
        dec_imm = {{11{sign_bit}}, from[31], from[19:12], from[20], from[30:21], 1'b0};
      default:
        dec_imm = '0;
    endcase
  end

  assign dec_funct3 = from[14:12];

  // A valid output must be fully known back through fetch and memory
  always_comb begin
    if (dec_valid) begin
      assert (!$isunknown({dec_op, dec_rd, dec_rs1, dec_rs2, dec_imm, dec_funct3}))
        else $error("instr_decode: unknown field at pc %h", dec_pc);
    end
  end

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    host_we,
  input  mem_sys_pkg::word_addr_t host_addr,
  input  mem_sys_pkg::word_t      host_wdata,
  input  logic                    fetch_req,
  input  mem_sys_pkg::word_addr_t fetch_addr,
  output logic                    fetch_gnt,
  output logic                    rd_valid,
  output logic                    mem_we,
  output mem_sys_pkg::word_addr_t mem_addr,
  output mem_sys_pkg::word_t      mem_wdata
);

  mem_sys_pkg::grant_e grant_q;

  // Host has fixed priority and never waits
  assign fetch_gnt = fetch_req && !host_we;
  assign mem_we    = host_we;
  assign mem_addr  = host_we ? host_addr : fetch_addr;
  assign mem_wdata = host_wdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_q <= mem_sys_pkg::GRANT_NONE;
    end else if (host_we) begin
      grant_q <= mem_sys_pkg::GRANT_HOST;
    end else if (fetch_req) begin
      grant_q <= mem_sys_pkg::GRANT_FETCH;
    end else begin
      grant_q <= mem_sys_pkg::GRANT_NONE;
    end
  end

  // Memory data is valid for fetch one cycle after its grant
  assign rd_valid = (grant_q == mem_sys_pkg::GRANT_FETCH);

  // A fetch request held off by a host write is still up next cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    (host_we && fetch_req) |=> fetch_req)
    else $error("mem_arbiter: fetch request dropped while stalled by a host write");

endmodule

// ==== mem_sys_pkg.sv ====
package mem_sys_pkg;

  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int PC_W = 32;

  // Word address, byte address bits 1..0 dropped
  typedef logic [ADDR_W-1:0] word_addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [PC_W-1:0] byte_pc_t;

  // Owner of the memory port in the previous cycle
  typedef enum logic [1:0] {
    GRANT_NONE  = 2'd0,
    GRANT_HOST  = 2'd1,
    GRANT_FETCH = 2'd2
  } grant_e;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the rv_frontend testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f rv_frontend.f --top-module tb_rv_frontend -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0

// ==== rv_frontend.f ====
mem_sys_pkg.sv
rv_isa_pkg.sv
unified_mem.sv
mem_arbiter.sv
fetch_unit.sv
instr_decode.sv
rv_frontend.sv
tb_rv_frontend.sv

// ==== rv_frontend.sv ====
`timescale 1ns/1ps

module rv_frontend #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    host_we,
  input  mem_sys_pkg::word_addr_t host_addr,
  input  mem_sys_pkg::word_t      host_wdata,
  input  logic                    redirect_valid,
  input  mem_sys_pkg::byte_pc_t   redirect_pc,
  input  logic                    dec_ready,
  output logic                    dec_valid,
  output mem_sys_pkg::byte_pc_t   dec_pc,
  output rv_isa_pkg::instr_op_e   dec_op,
  output rv_isa_pkg::reg_idx_t    dec_rd,
  output rv_isa_pkg::reg_idx_t    dec_rs1,
  output rv_isa_pkg::reg_idx_t    dec_rs2,
  output rv_isa_pkg::imm_t        dec_imm,
  output rv_isa_pkg::funct3_t     dec_funct3
);

  // Memory port
  logic                    mem_we;
  mem_sys_pkg::word_addr_t mem_addr;
  mem_sys_pkg::word_t      mem_wdata;
  mem_sys_pkg::word_t      mem_rdata;

  // Fetch side of the arbiter
  logic                    fetch_req;
  logic                    fetch_gnt;
  logic                    rd_valid;
  mem_sys_pkg::word_addr_t fetch_addr;

  // Fetch to decode
  logic                    fetched_valid;
  logic                    fetched_ready;
  rv_isa_pkg::instr_t      fetched_instr;
  mem_sys_pkg::byte_pc_t   fetched_pc;

  unified_mem #(
    .MEM_WORDS(MEM_WORDS)
  ) unified_mem_inst (
    .clk      (clk),
    .mem_we   (mem_we),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata)
  );

  mem_arbiter mem_arbiter_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .host_we   (host_we),
    .host_addr (host_addr),
    .host_wdata(host_wdata),
    .fetch_req (fetch_req),
    .fetch_addr(fetch_addr),
    .fetch_gnt (fetch_gnt),
    .rd_valid  (rd_valid),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata)
  );

  fetch_unit #(
    .MEM_WORDS(MEM_WORDS)
  ) fetch_unit_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_valid(redirect_valid),
    .redirect_pc   (redirect_pc),
    .fetch_gnt     (fetch_gnt),
    .rd_valid      (rd_valid),
    .mem_rdata     (mem_rdata),
    .fetched_ready (fetched_ready),
    .fetch_req     (fetch_req),
    .fetch_addr    (fetch_addr),
    .fetched_valid (fetched_valid),
    .fetched_instr (fetched_instr),
    .fetched_pc    (fetched_pc)
  );

  instr_decode instr_decode_inst (
    .fetched_valid(fetched_valid),
    .fetched_instr(fetched_instr),
    .fetched_pc   (fetched_pc),
    .dec_ready    (dec_ready),
    .fetched_ready(fetched_ready),
    .dec_valid    (dec_valid),
    .dec_pc       (dec_pc),
    .dec_op       (dec_op),
    .dec_rd       (dec_rd),
    .dec_rs1      (dec_rs1),
    .dec_rs2      (dec_rs2),
    .dec_imm      (dec_imm),
    .dec_funct3   (dec_funct3)
  );

endmodule

// ==== rv_frontend_stim.txt ====
# L word_addr word | R redirect_pc | W word_addr word (host write while fetching)
# E pc op rd rs1 rs2 imm funct3, all fields hex
L 0000 407302b3
L 0001 ffb58513
L 0002 00c6aa23
L 0003 fe208ce3
L 0004 123453b7
L 0005 001000ef
L 0006 12345672
L 0007 0000707f
L 0008 00000013
L 0009 00000013
L 000a 00000013
L 000b 00000013
L 0010 00812203
L 0011 fffff497
L 0012 00008067
L 0013 0ff0000f
L 0014 00000073
L 0015 305312f3
L 0016 00419193
L 0017 00019863
L 0018 00000013
L 0019 00000013
L 001a 00000013
L 001b 00000013
L 0020 00100093
L 0021 00108133
L 0022 fe208fa3
L 0023 ffdff06f
L 0024 00000013
L 0025 00000013
L 0026 00000013
L 0027 00000013
R 00000000
E 00000000 5 05 06 07 00000407 0
E 00000004 2 0a 0b 00 fffffffb 0
E 00000008 4 00 0d 0c 00000014 2
E 0000000c 7 00 01 02 fffffff8 0
E 00000010 6 07 00 00 12345000 5
E 00000014 9 01 00 00 00000800 0
E 00000018 b 00 00 00 00000000 5
E 0000001c b 00 00 00 00000000 7
R 00000040
W 0200 deadbeef
W 0201 01234567
W 0202 89abcdef
W 0203 0badf00d
E 00000040 0 04 02 00 00000008 2
E 00000044 3 09 00 00 fffff000 7
E 00000048 8 00 01 00 00000000 0
E 0000004c 1 00 00 00 000000ff 0
E 00000050 a 00 00 00 00000000 0
E 00000054 a 05 06 00 00000305 1
E 00000058 2 03 03 00 00000004 1
E 0000005c 7 00 03 00 00000010 1
R 00000080
E 00000080 2 01 00 00 00000001 0
E 00000084 5 02 01 01 00000001 0
E 00000088 4 00 01 02 ffffffff 0
E 0000008c 9 00 00 00 fffffffc 7
R 00000008
E 00000008 4 00 0d 0c 00000014 2
E 0000000c 7 00 01 02 fffffff8 0

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

  // Field widths fixed by the base ISA
  localparam int XLEN = 32;
  localparam int REG_IDX_W = 5;
  localparam int FUNCT3_W = 3;
  localparam int OPCODE_W = 5;

  typedef logic [XLEN-1:0] instr_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [XLEN-1:0] imm_t;
  typedef logic [FUNCT3_W-1:0] funct3_t;

  // Opcode bits 6..2, the two low bits are 11 for all 32-bit encodings
  typedef logic [OPCODE_W-1:0] opcode_t;

  localparam logic [1:0] LEN_32 = 2'b11;

  localparam opcode_t OPC_LOAD     = 5'b00000;
  localparam opcode_t OPC_MISC_MEM = 5'b00011;
  localparam opcode_t OPC_OP_IMM   = 5'b00100;
  localparam opcode_t OPC_AUIPC    = 5'b00101;
  localparam opcode_t OPC_STORE    = 5'b01000;
  localparam opcode_t OPC_OP       = 5'b01100;
  localparam opcode_t OPC_LUI      = 5'b01101;
  localparam opcode_t OPC_BRANCH   = 5'b11000;
  localparam opcode_t OPC_JALR     = 5'b11001;
  localparam opcode_t OPC_JAL      = 5'b11011;
  localparam opcode_t OPC_SYSTEM   = 5'b11100;

  // Operation class, numbered in this order on the output
  typedef enum logic [3:0] {
    INSTR_LOAD     = 4'd0,
    INSTR_MISC_MEM = 4'd1,
    INSTR_OP_IMM   = 4'd2,
    INSTR_AUIPC    = 4'd3,
    INSTR_STORE    = 4'd4,
    INSTR_OP       = 4'd5,
    INSTR_LUI      = 4'd6,
    INSTR_BRANCH   = 4'd7,
    INSTR_JALR     = 4'd8,
    INSTR_JAL      = 4'd9,
    INSTR_SYSTEM   = 4'd10,
    INSTR_INVAL    = 4'd11
  } instr_op_e;

  typedef enum logic [2:0] {
    INSTR_R        = 3'd0,
    INSTR_I        = 3'd1,
    INSTR_S        = 3'd2,
    INSTR_B        = 3'd3,
    INSTR_U        = 3'd4,
    INSTR_J        = 3'd5,
    INSTR_FMT_NONE = 3'd6
  } instr_fmt_e;

endpackage

// ==== tb_rv_frontend.sv ====
`timescale 1ns/1ps

module tb_rv_frontend;

  localparam int MEM_WORDS = 1024;
  localparam int CLK_PERIOD = 4;
  localparam int CYCLES_PER_EXPECT = 60;
  localparam string STIM_FILE = "rv_frontend_stim.txt";

  logic                    clk;
  logic                    rst_n;
  logic                    host_we;
  mem_sys_pkg::word_addr_t host_addr;
  mem_sys_pkg::word_t      host_wdata;
  logic                    redirect_valid;
  mem_sys_pkg::byte_pc_t   redirect_pc;
  logic                    dec_ready;
  logic                    dec_valid;
  mem_sys_pkg::byte_pc_t   dec_pc;
  rv_isa_pkg::instr_op_e   dec_op;
  rv_isa_pkg::reg_idx_t    dec_rd;
  rv_isa_pkg::reg_idx_t    dec_rs1;
  rv_isa_pkg::reg_idx_t    dec_rs2;
  rv_isa_pkg::imm_t        dec_imm;
  rv_isa_pkg::funct3_t     dec_funct3;

  // Stimulus and expected records from the stim file
  logic [15:0] load_addr_q[$];
  logic [31:0] load_data_q[$];
  logic [15:0] wr_addr_q[$];
  logic [31:0] wr_data_q[$];
  logic [31:0] test_pc_q[$];
  int          test_exp_q[$];
  int          test_wr_q[$];
  logic [31:0] exp_q[$][7];

  integer seed;
  logic   parsed;
  int     exp_idx;
  int     wr_idx;
  int     cur_errs;
  int     tests_passed;
  int     tests_failed;

  rv_frontend #(
    .MEM_WORDS(MEM_WORDS)
  ) rv_frontend_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .host_we       (host_we),
    .host_addr     (host_addr),
    .host_wdata    (host_wdata),
    .redirect_valid(redirect_valid),
    .redirect_pc   (redirect_pc),
    .dec_ready     (dec_ready),
    .dec_valid     (dec_valid),
    .dec_pc        (dec_pc),
    .dec_op        (dec_op),
    .dec_rd        (dec_rd),
    .dec_rs1       (dec_rs1),
    .dec_rs2       (dec_rs2),
    .dec_imm       (dec_imm),
    .dec_funct3    (dec_funct3)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic read_stim(output bit ok);
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [7];
    ok = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 2 && line[0] != "#") begin
        n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
        case (line[0])
          "L": begin
            load_addr_q.push_back(f[0][15:0]);
            load_data_q.push_back(f[1]);
          end
          "W": begin
            wr_addr_q.push_back(f[0][15:0]);
            wr_data_q.push_back(f[1]);
            test_wr_q[test_wr_q.size() - 1]++;
          end
          "R": begin
            test_pc_q.push_back(f[0]);
            test_exp_q.push_back(0);
            test_wr_q.push_back(0);
          end
          "E": begin
            exp_q.push_back(f);
            test_exp_q[test_exp_q.size() - 1]++;
          end
          default: ;
        endcase
      end
    end
    $fclose(fd);
    ok = 1'b1;
  endtask

  task automatic compare_field(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    if (exp !== got) begin
      $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
      cur_errs++;
    end
  endtask

  // One accepted output against the next expected record
  task automatic check_output();
    logic [31:0] e [7];
    e = exp_q[exp_idx];
    compare_field("dec_pc", e[0], dec_pc);
    compare_field("dec_op", e[1], {28'd0, dec_op});
    compare_field("dec_rd", e[2], {27'd0, dec_rd});
    compare_field("dec_rs1", e[3], {27'd0, dec_rs1});
    compare_field("dec_rs2", e[4], {27'd0, dec_rs2});
    compare_field("dec_imm", e[5], dec_imm);
    compare_field("dec_funct3", e[6], {29'd0, dec_funct3});
    exp_idx++;
  endtask

  task automatic run_test(input int t);
    int          got;
    int          wr_left;
    logic [31:0] rnd;
    got = 0;
    cur_errs = 0;
    wr_left = test_wr_q[t];
    // Redirect cycle takes no output, so nothing old slips through
    @(negedge clk);
    redirect_valid = 1'b1;
    redirect_pc = test_pc_q[t];
    dec_ready = 1'b0;
    host_we = 1'b0;
    while (got < test_exp_q[t] || wr_left > 0) begin
      @(negedge clk);
      redirect_valid = 1'b0;
      rnd = $random(seed);
      // Outputs are held back once every record of this test is taken
      dec_ready = (got < test_exp_q[t]) && (rnd[0] | rnd[1]);
      host_we = 1'b0;
      if (wr_left > 0 && rnd[2]) begin
        host_we = 1'b1;
        host_addr = wr_addr_q[wr_idx];
        host_wdata = wr_data_q[wr_idx];
        wr_idx++;
        wr_left--;
      end
      // Mid low phase, the transfer happens at the next rising edge
      #1;
      if (dec_valid && dec_ready && got < test_exp_q[t]) begin
        check_output();
        got++;
      end
    end
    // Freeing one old slot draws a read that the next redirect has to drop
    @(negedge clk);
    host_we = 1'b0;
    dec_ready = 1'b1;
    if (cur_errs == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("Test %0d redirect to %h: %0d outputs checked, %0d errors", t,
             test_pc_q[t], got, cur_errs);
  endtask

  initial begin
    bit ok;
    clk = 1'b0;
    rst_n = 1'b0;
    host_we = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    redirect_valid = 1'b0;
    redirect_pc = '0;
    dec_ready = 1'b0;
    seed = 32'h7847_c8c8;
    parsed = 1'b0;
    exp_idx = 0;
    wr_idx = 0;
    tests_passed = 0;
    tests_failed = 0;
    read_stim(ok);
    if (!ok) begin
      $display("Could not open the stimulus file %s", STIM_FILE);
      $display("Simulation failed");
      $finish;
    end else begin
      parsed = 1'b1;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      // Program load through the host port
      foreach (load_addr_q[i]) begin
        @(negedge clk);
        host_we = 1'b1;
        host_addr = load_addr_q[i];
        host_wdata = load_data_q[i];
      end
      @(negedge clk);
      host_we = 1'b0;
      foreach (test_pc_q[t]) begin
        run_test(t);
      end
      $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && tests_passed > 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

  // Watchdog sized from the stim contents
  initial begin
    longint limit;
    wait (parsed);
    limit = (longint'(CYCLES_PER_EXPECT) * exp_q.size() + load_addr_q.size() +
             wr_addr_q.size() + 2 * test_pc_q.size() + 20) * CLK_PERIOD;
    #(limit);
    $display("Timeout: expected outputs did not arrive within %0d ns", limit);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== unified_mem.sv ====
`timescale 1ns/1ps

module unified_mem #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                   clk,
  input  logic                   mem_we,
  input  mem_sys_pkg::word_addr_t mem_addr,
  input  mem_sys_pkg::word_t      mem_wdata,
  output mem_sys_pkg::word_t      mem_rdata
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  mem_sys_pkg::word_t mem [MEM_WORDS];
  logic [IDX_W-1:0] idx;

  assign idx = mem_addr[IDX_W-1:0];

  // Read data is registered every cycle, one cycle of latency
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[idx] <= mem_wdata;
    end
    mem_rdata <= mem[idx];
  end

  // Host loads must stay inside the array
  assert property (@(posedge clk) mem_we |-> (mem_addr < MEM_WORDS))
    else $error("unified_mem: write address %0d beyond %0d words", mem_addr, MEM_WORDS);

endmodule
